// File: Bender.yml
package:
  name: wdma_dat_in

sources:
  - common/wdma_cfg_pkg.sv
  - common/wdma_data_pkg.sv
  - source/wdma_pipe_fifo.sv
  - source/wdma_nan_counter.sv
  - wdma_dat_in/wdma_beat_tracker.sv
  - wdma_dat_in/wdma_lane_router.sv
  - wdma_dat_in/wdma_dat_in.sv
  - target: simulation
    files:
      - sim/wdma_dat_in_assertions.sv
      - sim/tb_wdma_dat_in.sv

// File: build.f
common/wdma_cfg_pkg.sv
common/wdma_data_pkg.sv
source/wdma_pipe_fifo.sv
source/wdma_nan_counter.sv
wdma_dat_in/wdma_beat_tracker.sv
wdma_dat_in/wdma_lane_router.sv
wdma_dat_in/wdma_dat_in.sv
sim/wdma_dat_in_assertions.sv
sim/tb_wdma_dat_in.sv

// File: common/wdma_cfg_pkg.sv
// write-DMA input configuration package: precision codes, command and status widths
`default_nettype none

package wdma_cfg_pkg;

  // ====================
  // output precision
  // ====================

  // 2-bit code from the output precision register
  typedef logic [1:0] precision_t;

  localparam precision_t prec_int8  = 2'd0;
  localparam precision_t prec_int16 = 2'd1;
  localparam precision_t prec_fp16  = 2'd2;

  // ====================
  // split command
  // ====================

  // beat count minus one for one burst
  localparam int spt_size_w = 14;

  typedef logic [spt_size_w-1:0] spt_size_t;

  // ====================
  // status
  // ====================

  // saturating NaN element counter
  localparam int nan_cnt_w = 32;

  typedef logic [nan_cnt_w-1:0] nan_cnt_t;

endpackage

`default_nettype wire

// File: common/wdma_data_pkg.sv
// write-DMA input data package: word width, lane count and the fp16 view of a data word
`default_nettype none

package wdma_data_pkg;

  // ====================
  // sizes
  // ====================

  // one datapath output word
  localparam int dw = 256;

  // lane FIFOs behind the router
  localparam int lane_num = 4;

  // fp16 elements in one word
  localparam int fp16_elems = 16;

  // ====================
  // element and word types
  // ====================

  // one half-precision element, sign at the top
  typedef struct packed {
    logic       sign;
    logic [4:0] expo;
    logic [9:0] mant;
  } fp16_t;

  // exponent value shared by inf and NaN
  localparam logic [4:0] fp16_expo_max = 5'h1f;

  // same word seen as raw bits or as packed fp16 elements
  // element 0 sits in bits [15:0]
  typedef union packed {
    logic [dw-1:0]               raw;
    fp16_t [fp16_elems-1:0]      elem;
  } dat_word_t;

  // one enable bit per lane
  typedef logic [lane_num-1:0] lane_sel_t;

endpackage

`default_nettype wire

// File: sim/tb_wdma_dat_in.sv
// testbench for the write-DMA data input covering lane routing, NaN status count and back-pressure
`default_nettype none

module tb_wdma_dat_in;
  import wdma_cfg_pkg::*;
  import wdma_data_pkg::*;

  localparam int          clk_half     = 50;
  localparam int          reset_cycles = 16;
  localparam logic [31:0] rand_seed    = 32'h902d;
  localparam int          row_num      = 9;

  // one burst with precision, size field, NaN placement seed and an op_load flag
  typedef struct packed {
    precision_t  prec;
    spt_size_t   size;
    logic [7:0]  seed;
    logic        load;
  } row_t;

  localparam row_t stim_tab [row_num] = '{
    '{prec_int8,  14'd6,  8'd3,  1'b0},
    '{prec_int8,  14'd2,  8'd7,  1'b0},
    '{prec_fp16,  14'd7,  8'd1,  1'b0},
    '{prec_int16, 14'd4,  8'd9,  1'b0},
    '{prec_fp16,  14'd2,  8'd4,  1'b1},
    '{prec_fp16,  14'd10, 8'd12, 1'b0},
    '{prec_int8,  14'd12, 8'd5,  1'b0},
    '{prec_int16, 14'd0,  8'd2,  1'b0},
    '{prec_fp16,  14'd5,  8'd8,  1'b0}
  };

  logic                  nvdla_core_clk = 1'b0;
  logic                  nvdla_core_rstn;
  logic                  op_load;
  precision_t            out_precision;
  logic                  spt_pvld;
  wire                   spt_prdy;
  spt_size_t             spt_pd;
  logic                  dp2wdma_valid;
  wire                   dp2wdma_ready;
  dat_word_t             dp2wdma_pd;
  logic [lane_num-1:0]   rd_prdy;
  wire  [lane_num-1:0]   rd_pvld;
  wire  dat_word_t       rd_pd [lane_num];
  wire  nan_cnt_t        nan_output_num;

  dat_word_t   lane_q [lane_num][$];
  nan_cnt_t    exp_nan;
  logic [31:0] dat_state;
  logic [31:0] bp_state;
  int          word_errs;
  int          count_errs;
  int          flag_errs;
  int          cycle_cnt;
  int          cycle_limit;

  wdma_dat_in wdma_dat_in_inst (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .out_precision   (out_precision),
    .spt_pvld        (spt_pvld),
    .spt_prdy        (spt_prdy),
    .spt_pd          (spt_pd),
    .dp2wdma_valid   (dp2wdma_valid),
    .dp2wdma_ready   (dp2wdma_ready),
    .dp2wdma_pd      (dp2wdma_pd),
    .dfifo0_rd_pvld  (rd_pvld[0]),
    .dfifo0_rd_prdy  (rd_prdy[0]),
    .dfifo0_rd_pd    (rd_pd[0]),
    .dfifo1_rd_pvld  (rd_pvld[1]),
    .dfifo1_rd_prdy  (rd_prdy[1]),
    .dfifo1_rd_pd    (rd_pd[1]),
    .dfifo2_rd_pvld  (rd_pvld[2]),
    .dfifo2_rd_prdy  (rd_prdy[2]),
    .dfifo2_rd_pd    (rd_pd[2]),
    .dfifo3_rd_pvld  (rd_pvld[3]),
    .dfifo3_rd_prdy  (rd_prdy[3]),
    .dfifo3_rd_pd    (rd_pd[3]),
    .nan_output_num  (nan_output_num)
  );

  always #(clk_half) nvdla_core_clk = ~nvdla_core_clk;

  // ====================
  // helpers
  // ====================

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int total_beats();
    int sum;
    sum = 0;
    for (int r = 0; r < row_num; r++) begin
      sum += int'(stim_tab[r].size) + 1;
    end
    return sum;
  endfunction

  function automatic int pending_words();
    int sum;
    sum = 0;
    for (int n = 0; n < lane_num; n++) begin
      sum += lane_q[n].size();
    end
    return sum;
  endfunction

  // NaN is all-ones exponent with a non-zero mantissa
  function automatic nan_cnt_t count_nan(input dat_word_t w);
    nan_cnt_t n;
    n = '0;
    for (int i = 0; i < fp16_elems; i++) begin
      if (w.raw[16*i+10 +: 5] == 5'h1f && w.raw[16*i +: 10] != 10'h0) begin
        n = n + 1;
      end
    end
    return n;
  endfunction

  // random word with one NaN and one infinity planted
  task automatic make_word(input logic [7:0] seed, input int beat, output dat_word_t w);
    int nan_pos;
    int inf_pos;
    for (int k = 0; k < dw / 32; k++) begin
      dat_state = xorshift(dat_state);
      w.raw[32*k +: 32] = dat_state;
    end
    nan_pos = (seed + beat) % fp16_elems;
    inf_pos = (seed + beat + 5) % fp16_elems;
    w.raw[16*nan_pos+10 +: 5] = 5'h1f;
    w.raw[16*nan_pos +: 10]   = dat_state[9:0] | 10'h1;
    w.raw[16*inf_pos+10 +: 5] = 5'h1f;
    w.raw[16*inf_pos +: 10]   = 10'h0;
  endtask

  // expected lane contents for one accepted beat
  task automatic route_beat(input precision_t prec, input int beat, input dat_word_t w);
    dat_word_t upper;
    // odd lane of a pair sees the upper half moved down
    upper.raw = w.raw >> (dw / 2);
    if (prec == prec_int8) begin
      lane_q[beat % lane_num].push_back(w);
    end else if (beat % 2 == 0) begin
      lane_q[0].push_back(w);
      lane_q[1].push_back(upper);
    end else begin
      lane_q[2].push_back(w);
      lane_q[3].push_back(upper);
    end
  endtask

  task automatic check_word(input dat_word_t got, input dat_word_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got.raw, exp.raw);
      word_errs++;
    end
  endtask

  task automatic check_count(input nan_cnt_t got, input nan_cnt_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
      count_errs++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
      flag_errs++;
    end
  endtask

  // ====================
  // stimulus
  // ====================

  task automatic send_command(input spt_size_t size);
    spt_pvld <= 1'b1;
    spt_pd   <= size;
    do @(posedge nvdla_core_clk); while (!(spt_pvld && spt_prdy));
    spt_pvld <= 1'b0;
  endtask

  task automatic send_burst(input row_t row);
    dat_word_t w;
    nan_cnt_t  n;
    for (int b = 0; b <= int'(row.size); b++) begin
      make_word(row.seed, b, w);
      dp2wdma_valid <= 1'b1;
      dp2wdma_pd    <= w;
      do @(posedge nvdla_core_clk); while (!(dp2wdma_valid && dp2wdma_ready));
      route_beat(row.prec, b, w);
      if (row.prec == prec_fp16) begin
        n = count_nan(w);
        if (exp_nan > ({nan_cnt_w{1'b1}} - n)) begin
          exp_nan = '1;
        end else begin
          exp_nan = exp_nan + n;
        end
      end
    end
    dp2wdma_valid <= 1'b0;
  endtask

  initial begin : driver
    nvdla_core_rstn = 1'b0;
    op_load         = 1'b0;
    out_precision   = prec_int8;
    spt_pvld        = 1'b0;
    spt_pd          = '0;
    dp2wdma_valid   = 1'b0;
    dp2wdma_pd      = '0;
    rd_prdy         = '0;
    exp_nan         = '0;
    dat_state       = rand_seed;
    bp_state        = xorshift(rand_seed);
    word_errs       = 0;
    count_errs      = 0;
    flag_errs       = 0;
    cycle_cnt       = 0;
    cycle_limit     = 4 * total_beats() + reset_cycles;

    repeat (reset_cycles) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    @(negedge nvdla_core_clk);
    for (int n = 0; n < lane_num; n++) begin
      check_flag(rd_pvld[n], 1'b0, $sformatf("lane %0d valid after reset", n));
    end
    check_flag(spt_prdy, 1'b1, "command ready after reset");
    check_count(nan_output_num, '0, "NaN count after reset");
    @(posedge nvdla_core_clk);

    for (int r = 0; r < row_num; r++) begin
      out_precision <= stim_tab[r].prec;
      send_command(stim_tab[r].size);
      send_burst(stim_tab[r]);
      @(negedge nvdla_core_clk);
      check_count(nan_output_num, exp_nan, $sformatf("NaN count after row %0d", r));
      @(posedge nvdla_core_clk);
      if (stim_tab[r].load) begin
        op_load <= 1'b1;
        @(posedge nvdla_core_clk);
        op_load <= 1'b0;
        exp_nan = '0;
        @(negedge nvdla_core_clk);
        check_count(nan_output_num, exp_nan, "NaN count after op_load");
        @(posedge nvdla_core_clk);
      end
    end

    // drain the lanes and watch for stray words
    while (pending_words() != 0) @(posedge nvdla_core_clk);
    repeat (4) @(posedge nvdla_core_clk);

    $display("errors: %0d word, %0d count, %0d flag", word_errs, count_errs, flag_errs);
    if (word_errs + count_errs + flag_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // ====================
  // lane side
  // ====================

  // ready high about three cycles in four
  always @(posedge nvdla_core_clk) begin
    bp_state = xorshift(bp_state);
    rd_prdy <= bp_state[3:0] | bp_state[11:8];
  end

  always @(posedge nvdla_core_clk) begin : lane_monitor
    dat_word_t exp_w;
    for (int n = 0; n < lane_num; n++) begin
      if (rd_pvld[n] && rd_prdy[n]) begin
        if (lane_q[n].size() == 0) begin
          $display("lane %0d delivered a word at %0t when none was expected", n, $time);
          word_errs++;
        end else begin
          exp_w = lane_q[n].pop_front();
          check_word(rd_pd[n], exp_w, $sformatf("lane %0d word", n));
        end
      end
    end
  end

  always @(posedge nvdla_core_clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sim/wdma_dat_in_assertions.sv
// write-DMA data input assertions: command ordering and NaN status counter behavior
`default_nettype none

module wdma_dat_in_assertions (
  input logic                   nvdla_core_clk,
  input logic                   nvdla_core_rstn,
  input logic                   op_load,
  input logic                   dp2wdma_valid,
  input logic                   spt_vld,
  input wdma_cfg_pkg::nan_cnt_t nan_output_num
);

  // data only once its command is held
  valid_after_cmd: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    $rose(dp2wdma_valid) |-> spt_vld
  ) else $error("data valid rose with no command held");

  // only op_load may lower the count
  count_no_drop: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (nan_output_num < $past(nan_output_num)) |-> $past(op_load)
  ) else $error("NaN count dropped without op_load");

  // saturated count holds
  count_saturates: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (nan_output_num == '1) && !op_load |=> (nan_output_num == '1)
  ) else $error("NaN count left all ones without op_load");

endmodule

bind wdma_dat_in wdma_dat_in_assertions u_dat_in_assertions (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .op_load         (op_load),
  .dp2wdma_valid   (dp2wdma_valid),
  .spt_vld         (u_beat_tracker.spt_vld),
  .nan_output_num  (nan_output_num)
);

`default_nettype wire

// File: source/wdma_nan_counter.sv
// write-DMA NaN counter: counts fp16 NaN elements of accepted beats into a saturating status
`default_nettype none

module wdma_nan_counter (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  logic                     op_load,
  input  wdma_cfg_pkg::precision_t out_precision,
  input  logic                     in_dat_accept,
  input  wdma_data_pkg::dat_word_t dp2wdma_pd,
  output wdma_cfg_pkg::nan_cnt_t   nan_output_num
);
  import wdma_cfg_pkg::*;
  import wdma_data_pkg::*;

  logic                              cfg_do_fp16;
  logic [$clog2(fp16_elems+1)-1:0]   beat_nan_num;
  logic [nan_cnt_w:0]                cnt_sum;
  nan_cnt_t                          cnt_nxt;

  assign cfg_do_fp16 = (out_precision == prec_fp16);

  // ====================
  // per-beat detection
  // ====================

  // NaN is max exponent with a non-zero mantissa, inf does not count
  always_comb begin
    beat_nan_num = '0;
    for (int i = 0; i < fp16_elems; i++) begin
      if (cfg_do_fp16 && (dp2wdma_pd.elem[i].expo == fp16_expo_max) &&
          (dp2wdma_pd.elem[i].mant != '0)) begin
        beat_nan_num = beat_nan_num + 1'b1;
      end
    end
  end

  // ====================
  // saturating status
  // ====================

  // carry out means the sum wrapped, so pin at all ones
  assign cnt_sum = {1'b0, nan_output_num} + beat_nan_num;
  assign cnt_nxt = cnt_sum[nan_cnt_w] ? '1 : cnt_sum[nan_cnt_w-1:0];

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      nan_output_num <= '0;
    end else if (op_load) begin
      nan_output_num <= '0;
    end else if (in_dat_accept) begin
      nan_output_num <= cnt_nxt;
    end
  end

endmodule

`default_nettype wire

// File: source/wdma_pipe_fifo.sv
// lane pipe FIFO: two-entry valid/ready buffer with registered data and full throughput
`default_nettype none

module wdma_pipe_fifo (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  logic                     wr_pvld,
  output logic                     wr_prdy,
  input  wdma_data_pkg::dat_word_t wr_pd,
  output logic                     rd_pvld,
  input  logic                     rd_prdy,
  output wdma_data_pkg::dat_word_t rd_pd
);
  import wdma_data_pkg::*;

  dat_word_t  mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       wr_en;
  logic       rd_en;

  // full only with both entries taken
  assign wr_prdy = (count != 2'd2);
  assign rd_pvld = (count != 2'd0);
  assign rd_pd   = mem[rd_ptr];

  assign wr_en = wr_pvld & wr_prdy;
  assign rd_en = rd_pvld & rd_prdy;

  always_ff @(posedge nvdla_core_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_pd;
    end
  end

  // pointers and occupancy
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ~wr_ptr;
      end
      if (rd_en) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: wdma_dat_in/wdma_beat_tracker.sv
// write-DMA beat tracker: holds the split command and counts the beats of its burst
`default_nettype none

module wdma_beat_tracker (
  input  logic                    nvdla_core_clk,
  input  logic                    nvdla_core_rstn,
  input  logic                    spt_pvld,
  output logic                    spt_prdy,
  input  wdma_cfg_pkg::spt_size_t spt_pd,
  input  logic                    in_dat_accept,
  output wdma_cfg_pkg::spt_size_t beat_count,
  output logic                    is_last_beat
);
  import wdma_cfg_pkg::*;

  spt_size_t spt_size;
  logic      spt_vld;
  logic      spt_done;
  logic      spt_load;

  // ====================
  // command hold
  // ====================

  // last beat of the held burst goes in this cycle
  assign spt_done = in_dat_accept & is_last_beat;

  // free slot, or the slot empties on this edge
  assign spt_prdy = ~spt_vld | spt_done;
  assign spt_load = spt_pvld & spt_prdy;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      spt_vld <= 1'b0;
    end else if (spt_prdy) begin
      spt_vld <= spt_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (spt_load) begin
      spt_size <= spt_pd;
    end
  end

  // ====================
  // beat counter
  // ====================

  // size field is beats minus one
  assign is_last_beat = (beat_count == spt_size);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      beat_count <= '0;
    end else if (in_dat_accept) begin
      if (is_last_beat) begin
        beat_count <= '0;
      end else begin
        beat_count <= beat_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: wdma_dat_in/wdma_dat_in.sv
// write-DMA data input that routes datapath beats into four lane FIFOs and counts fp16 NaNs
`default_nettype none

module wdma_dat_in (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  logic                     op_load,
  input  wdma_cfg_pkg::precision_t out_precision,
  input  logic                     spt_pvld,
  output logic                     spt_prdy,
  input  wdma_cfg_pkg::spt_size_t  spt_pd,
  input  logic                     dp2wdma_valid,
  output logic                     dp2wdma_ready,
  input  wdma_data_pkg::dat_word_t dp2wdma_pd,
  output logic                     dfifo0_rd_pvld,
  input  logic                     dfifo0_rd_prdy,
  output wdma_data_pkg::dat_word_t dfifo0_rd_pd,
  output logic                     dfifo1_rd_pvld,
  input  logic                     dfifo1_rd_prdy,
  output wdma_data_pkg::dat_word_t dfifo1_rd_pd,
  output logic                     dfifo2_rd_pvld,
  input  logic                     dfifo2_rd_prdy,
  output wdma_data_pkg::dat_word_t dfifo2_rd_pd,
  output logic                     dfifo3_rd_pvld,
  input  logic                     dfifo3_rd_prdy,
  output wdma_data_pkg::dat_word_t dfifo3_rd_pd,
  output wdma_cfg_pkg::nan_cnt_t   nan_output_num
);
  import wdma_cfg_pkg::*;
  import wdma_data_pkg::*;

  spt_size_t beat_count;
  logic      in_dat_accept;
  lane_sel_t lane_wr_pvld;
  lane_sel_t lane_wr_prdy;
  dat_word_t lane_wr_pd [lane_num];
  lane_sel_t lane_rd_pvld;
  lane_sel_t lane_rd_prdy;
  dat_word_t lane_rd_pd [lane_num];

  // ====================
  // command and routing
  // ====================

  wdma_beat_tracker u_beat_tracker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .spt_pvld        (spt_pvld),
    .spt_prdy        (spt_prdy),
    .spt_pd          (spt_pd),
    .in_dat_accept   (in_dat_accept),
    .beat_count      (beat_count),
    .is_last_beat    ()
  );

  wdma_lane_router u_lane_router (
    .out_precision (out_precision),
    .dp2wdma_valid (dp2wdma_valid),
    .dp2wdma_pd    (dp2wdma_pd),
    .beat_count    (beat_count),
    .lane_wr_prdy  (lane_wr_prdy),
    .lane_wr_pvld  (lane_wr_pvld),
    .lane_wr_pd    (lane_wr_pd),
    .dp2wdma_ready (dp2wdma_ready),
    .in_dat_accept (in_dat_accept)
  );

  wdma_nan_counter u_nan_counter (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .out_precision   (out_precision),
    .in_dat_accept   (in_dat_accept),
    .dp2wdma_pd      (dp2wdma_pd),
    .nan_output_num  (nan_output_num)
  );

  // ====================
  // lane FIFOs
  // ====================

  for (genvar i = 0; i < lane_num; i++) begin : g_dfifo
    wdma_pipe_fifo u_dfifo (
      .nvdla_core_clk  (nvdla_core_clk),
      .nvdla_core_rstn (nvdla_core_rstn),
      .wr_pvld         (lane_wr_pvld[i]),
      .wr_prdy         (lane_wr_prdy[i]),
      .wr_pd           (lane_wr_pd[i]),
      .rd_pvld         (lane_rd_pvld[i]),
      .rd_prdy         (lane_rd_prdy[i]),
      .rd_pd           (lane_rd_pd[i])
    );
  end

  // lane arrays to the named read ports
  assign lane_rd_prdy = {dfifo3_rd_prdy, dfifo2_rd_prdy, dfifo1_rd_prdy, dfifo0_rd_prdy};
  assign {dfifo3_rd_pvld, dfifo2_rd_pvld, dfifo1_rd_pvld, dfifo0_rd_pvld} = lane_rd_pvld;
  assign dfifo0_rd_pd = lane_rd_pd[0];
  assign dfifo1_rd_pd = lane_rd_pd[1];
  assign dfifo2_rd_pd = lane_rd_pd[2];
  assign dfifo3_rd_pd = lane_rd_pd[3];

endmodule

`default_nettype wire

// File: wdma_dat_in/wdma_lane_router.sv
// write-DMA lane router: per-beat lane enables, lane data slices and input ready merge
`default_nettype none

module wdma_lane_router (
  input  wdma_cfg_pkg::precision_t  out_precision,
  input  logic                      dp2wdma_valid,
  input  wdma_data_pkg::dat_word_t  dp2wdma_pd,
  input  wdma_cfg_pkg::spt_size_t   beat_count,
  input  wdma_data_pkg::lane_sel_t  lane_wr_prdy,
  output wdma_data_pkg::lane_sel_t  lane_wr_pvld,
  output wdma_data_pkg::dat_word_t  lane_wr_pd [wdma_data_pkg::lane_num],
  output logic                      dp2wdma_ready,
  output logic                      in_dat_accept
);
  import wdma_cfg_pkg::*;
  import wdma_data_pkg::*;

  logic      cfg_do_8;
  lane_sel_t lane_en;

  // any non-int8 code takes the 16-bit path
  assign cfg_do_8 = (out_precision == prec_int8);

  // ====================
  // lane enables
  // ====================

  always_comb begin
    lane_en = '0;
    if (cfg_do_8) begin
      // one lane per beat, rotating
      lane_en[beat_count[1:0]] = 1'b1;
    end else if (beat_count[0]) begin
      lane_en = 4'b1100;
    end else begin
      lane_en = 4'b0011;
    end
  end

  // ====================
  // lane data
  // ====================

  // odd lanes of a 16-bit pair carry the upper half, zero extended
  always_comb begin
    for (int i = 0; i < lane_num; i++) begin
      if (!cfg_do_8 && (i % 2 == 1)) begin
        lane_wr_pd[i].raw = {{(dw/2){1'b0}}, dp2wdma_pd.raw[dw-1:dw/2]};
      end else begin
        lane_wr_pd[i] = dp2wdma_pd;
      end
    end
  end

  // ====================
  // handshake merge
  // ====================

  // lanes not enabled this beat never hold it back
  assign dp2wdma_ready = &(lane_wr_prdy | ~lane_en);
  assign in_dat_accept = dp2wdma_valid & dp2wdma_ready;

  // all enabled lanes write together or none does
  assign lane_wr_pvld = lane_en & {lane_num{in_dat_accept}};

endmodule

`default_nettype wire
